//--- Makefile
# Verilator build and run for the rx decimation chain

VERILATOR ?= verilator
TOP       ?= tb_iq_decimator
RTL_TOP   ?= iq_decimator
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RTL_SRCS  ?= logic/rx_pkg.sv logic/rate_strobe.sv logic/cic_decimator.sv logic/iq_decimator.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass or fail comes from the log, a nonzero exit also counts as failure
run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif [ $$status -ne 0 ] || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended abnormally, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/cic_ref_model.svh
`ifndef CIC_REF_MODEL_SVH
`define CIC_REF_MODEL_SVH

// DC reference numbers for the two-filter decimation chain
// included inside the bench module, after its rx_pkg import

localparam int strobes_per_out = ratio_1 * ratio_2; // 400 inputs per output
localparam int phase_outputs = 10;   // output periods per stimulus phase
localparam int num_phases = 5;
localparam int settle_outputs = 6;   // first fully settled output of a DC phase

// 50 output periods, plus room for the gapped phase and reset
localparam int timeout_cycles = num_phases * phase_outputs * strobes_per_out + 5000;

localparam logic signed [sample_w-1:0] full_pos = {1'b0, {(sample_w - 1){1'b1}}};
localparam logic signed [sample_w-1:0] full_neg = {1'b1, {(sample_w - 1){1'b0}}};

// DC gain of one N-stage CIC, R**N
function automatic longint dc_gain(input int ratio);
  longint g;
  g = 1;
  for (int s = 0; s < cic_stages; s++) begin
    g = g * longint'(ratio);
  end
  return g;
endfunction

// one filter at DC
// gain, then floor by the lsbs the output truncation drops
function automatic longint cic_dc_out(input longint x, input int ratio,
                                      input int in_w, input int o_w);
  int shift;
  shift = in_w + bit_growth(cic_stages, ratio) - o_w; // 16 first filter, 13 second
  return (x * dc_gain(ratio)) >>> shift; // arithmetic shift floors toward -inf
endfunction

// settled chain output for a held input level
function automatic logic signed [out_w-1:0] expected_dc_out(
  input logic signed [sample_w-1:0] x
);
  longint stage1;
  longint stage2;
  stage1 = cic_dc_out(longint'(x), ratio_1, sample_w, sample_w); // unity gain
  stage2 = cic_dc_out(stage1, ratio_2, sample_w, out_w);         // x*390625/8192
  return out_w'(stage2);
endfunction

// outputs owed after a given number of input strobes
function automatic int outputs_due(input int strobes);
  return strobes / strobes_per_out;
endfunction

// true on the strobe that completes an output period
function automatic bit is_output_point(input int strobes);
  return (strobes > 0) && (strobes % strobes_per_out == 0);
endfunction

`endif

//--- bench/tb_iq_decimator.sv
`timescale 1ns/1ps

// testbench for the rx decimation chain
// five stimulus phases, all checking done by concurrent assertions
module tb_iq_decimator
  import rx_pkg::*;
();

  localparam int clk_half = 4; // 8 ns clock

  logic clock;
  logic rst;
  logic in_strobe;
  logic signed [sample_w-1:0] in_i;
  logic signed [sample_w-1:0] in_q;
  logic out_strobe;
  logic signed [out_w-1:0] out_i;
  logic signed [out_w-1:0] out_q;

  `include "cic_ref_model.svh"

  int in_count;     // input strobes since reset
  int out_count;    // output strobes since reset
  int cycle_count;  // for the timeout
  int phase_start;  // out_count when the phase began
  int settle_from;  // first checked output within the phase
  bit dc_check;     // exp_i / exp_q valid in this phase
  logic signed [out_w-1:0] exp_i;
  logic signed [out_w-1:0] exp_q;
  logic signed [out_w-1:0] out_min; // full-scale negative DC result
  logic signed [out_w-1:0] out_max; // full-scale positive DC result
  int strobe_errors;
  int value_errors;
  int range_errors;

  iq_decimator i_iq_decimator (
    .clock(clock),
    .rst(rst),
    .in_strobe(in_strobe),
    .in_i(in_i),
    .in_q(in_q),
    .out_strobe(out_strobe),
    .out_i(out_i),
    .out_q(out_q)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #clk_half clock = ~clock;
    end
  end

  // strobe bookkeeping, independent of the DUT's counters
  always @(posedge clock) begin
    if (rst) begin
      in_count <= 0;
      out_count <= 0;
    end else begin
      if (in_strobe) in_count <= in_count + 1;
      if (out_strobe) out_count <= out_count + 1;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("run did not finish within %0d clock cycles", timeout_cycles);
      print_error_counts();
      $display("Test failed");
      $finish;
    end
  end

  // out_strobe lands 3 edges after the strobe that completes a period of 400
  a_out_on_count : assert property (
    @(posedge clock) disable iff (rst)
    out_strobe |-> ($past(in_strobe, 3) && is_output_point($past(in_count, 2))
                    && (outputs_due($past(in_count, 2)) == out_count + 1))
  ) else begin
    strobe_errors++;
    $display("out_strobe at %t does not follow a completed period (inputs %0d, outputs %0d)",
             $time, in_count, out_count);
  end

  // and none is skipped
  a_out_due : assert property (
    @(posedge clock) disable iff (rst)
    ($past(in_strobe, 3) && is_output_point($past(in_count, 2))) |-> out_strobe
  ) else begin
    strobe_errors++;
    $display("missing out_strobe at %t after %0d input strobes", $time, in_count);
  end

  a_out_single : assert property (
    @(posedge clock) disable iff (rst)
    out_strobe |=> !out_strobe
  ) else begin
    strobe_errors++;
    $display("out_strobe high two cycles running at %t", $time);
  end

  // outputs hold between strobes
  a_out_hold : assert property (
    @(posedge clock) disable iff (rst)
    ((out_i != $past(out_i)) || (out_q != $past(out_q))) |-> out_strobe
  ) else begin
    strobe_errors++;
    $display("out_i or out_q changed without out_strobe at %t", $time);
  end

  a_value_i : assert property (
    @(posedge clock) disable iff (rst)
    (out_strobe && dc_check && (out_count - phase_start + 1 >= settle_from))
      |-> (out_i == exp_i)
  ) else begin
    value_errors++;
    $display("[FAIL] t=%t out_i expected %0d got %0d", $time, exp_i, out_i);
  end

  a_value_q : assert property (
    @(posedge clock) disable iff (rst)
    (out_strobe && dc_check && (out_count - phase_start + 1 >= settle_from))
      |-> (out_q == exp_q)
  ) else begin
    value_errors++;
    $display("[FAIL] t=%t out_q expected %0d got %0d", $time, exp_q, out_q);
  end

  // impulse response is all positive, so full-scale DC bounds every output
  a_range_i : assert property (
    @(posedge clock) disable iff (rst)
    out_strobe |-> ((out_i >= out_min) && (out_i <= out_max))
  ) else begin
    range_errors++;
    $display("[FAIL] t=%t out_i expected %0d to %0d got %0d",
             $time, out_min, out_max, out_i);
  end

  a_range_q : assert property (
    @(posedge clock) disable iff (rst)
    out_strobe |-> ((out_q >= out_min) && (out_q <= out_max))
  ) else begin
    range_errors++;
    $display("[FAIL] t=%t out_q expected %0d to %0d got %0d",
             $time, out_min, out_max, out_q);
  end

  // held levels, expected results from the DC model
  task automatic start_dc_phase(input logic signed [sample_w-1:0] lvl_i,
                                input logic signed [sample_w-1:0] lvl_q,
                                input int settle);
    in_i = lvl_i;
    in_q = lvl_q;
    exp_i = expected_dc_out(lvl_i);
    exp_q = expected_dc_out(lvl_q);
    phase_start = out_count;
    settle_from = settle;
    dc_check = 1'b1;
  endtask

  task automatic start_noise_phase();
    dc_check = 1'b0; // only the range checks apply
    phase_start = out_count;
  endtask

  // drive one cycle at a time until the phase has its outputs
  task automatic run_phase(input bit gapped, input bit noisy);
    int target;
    logic [31:0] rnd;
    target = out_count + phase_outputs;
    while (out_count < target) begin
      if (noisy) begin
        rnd = $urandom;
        in_i = rnd[sample_w-1:0];
        rnd = $urandom;
        in_q = rnd[sample_w-1:0];
      end
      if (gapped) begin
        in_strobe = ($urandom % 8) != 0; // roughly one gap in eight
      end else begin
        in_strobe = 1'b1;
      end
      @(posedge clock);
      #1;
    end
  endtask

  task automatic print_error_counts();
    $display("errors: strobe %0d, value %0d, range %0d after %0d outputs",
             strobe_errors, value_errors, range_errors, out_count);
  endtask

  initial begin
    logic [31:0] rnd;
    logic signed [sample_w-1:0] lvl_i;
    logic signed [sample_w-1:0] lvl_q;
    $timeformat(-9, 1, " ns", 10);
    void'($urandom(14));
    rst = 1'b1;
    in_strobe = 1'b0;
    in_i = '0;
    in_q = '0;
    dc_check = 1'b0;
    phase_start = 0;
    settle_from = 1;
    exp_i = '0;
    exp_q = '0;
    out_min = expected_dc_out(full_neg);
    out_max = expected_dc_out(full_pos);
    repeat (4) @(posedge clock);
    #1;
    rst = 1'b0;

    // zero input, filters start empty so every output counts
    start_dc_phase('0, '0, 1);
    run_phase(1'b0, 1'b0);

    // DC on I, negated level on Q
    lvl_i = sample_w'(77777);
    start_dc_phase(lvl_i, -lvl_i, settle_outputs);
    run_phase(1'b0, 1'b0);

    // both extremes at once, exercises the accumulator wrap
    start_dc_phase(full_pos, full_neg, settle_outputs);
    run_phase(1'b0, 1'b0);

    start_noise_phase();
    run_phase(1'b0, 1'b1);

    // back to DC after noise, strobe gapped at random
    rnd = $urandom;
    lvl_i = rnd[sample_w-1:0];
    rnd = $urandom;
    lvl_q = rnd[sample_w-1:0];
    start_dc_phase(lvl_i, lvl_q, settle_outputs);
    run_phase(1'b1, 1'b0);

    dc_check = 1'b0;
    in_strobe = 1'b0;
    repeat (4) @(posedge clock); // let the last checks sample
    print_error_counts();
    if (strobe_errors + value_errors + range_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- logic/cic_decimator.sv
`timescale 1ns/1ps

// N-stage CIC decimator, differential delay 1
// integrators run at the input strobe rate, combs at the decimated rate
// no pruning, every stage carries the full accumulator width
module cic_decimator
  import rx_pkg::*;
#(
  parameter int STAGES = 4,
  parameter int RATIO = 16,
  parameter int IN_W = 18,
  parameter int OUT_W = 18
) (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    in_strobe,  // input sample valid
  input  logic                    dec_strobe, // decimated sample clock
  input  logic signed [IN_W-1:0]  in_data,
  output logic signed [OUT_W-1:0] out_data    // held between dec_strobes
);

  // growth covers the full DC gain RATIO**STAGES
  localparam int GROWTH = bit_growth(STAGES, RATIO);
  localparam int ACC_W = IN_W + GROWTH;
  localparam int SHIFT = ACC_W - OUT_W; // lsbs dropped at the output

  logic signed [ACC_W-1:0] in_ext;             // sign-extended input
  logic signed [ACC_W-1:0] integ [STAGES];     // integrator state
  logic signed [ACC_W-1:0] comb_dly [STAGES];  // comb delay, one per stage
  logic signed [ACC_W-1:0] comb_out [STAGES];  // comb differences, combinational

  // output must not be wider than the accumulator
  if (SHIFT < 0) begin : g_width_check
    $error("cic_decimator: OUT_W wider than accumulator");
  end

  assign in_ext = {{GROWTH{in_data[IN_W-1]}}, in_data};

  // integrator chain
  // wraps modulo 2**ACC_W, which the combs undo exactly
  for (genvar s = 0; s < STAGES; s++) begin : g_integ
    logic signed [ACC_W-1:0] feed; // previous stage, or the input for stage 0

    if (s == 0) begin : g_first
      assign feed = in_ext;
    end else begin : g_next
      assign feed = integ[s-1];
    end

    always_ff @(posedge clock) begin
      if (rst) begin
        integ[s] <= '0;
      end else if (in_strobe) begin
        integ[s] <= integ[s] + feed; // free-running accumulate
      end
    end
  end

  // comb chain at the decimated rate
  // each stage: y = x - x_prev, x_prev captured on dec_strobe
  for (genvar c = 0; c < STAGES; c++) begin : g_comb
    logic signed [ACC_W-1:0] feed;

    if (c == 0) begin : g_first
      assign feed = integ[STAGES-1]; // last integrator, sampled at the decimation point
    end else begin : g_next
      assign feed = comb_out[c-1];
    end

    assign comb_out[c] = feed - comb_dly[c]; // wrap is harmless here too

    always_ff @(posedge clock) begin
      if (rst) begin
        comb_dly[c] <= '0;
      end else if (dec_strobe) begin
        comb_dly[c] <= feed;
      end
    end
  end

  // output register
  // top OUT_W bits of the last comb, i.e. arithmetic shift right by SHIFT
  always_ff @(posedge clock) begin
    if (rst) begin
      out_data <= '0;
    end else if (dec_strobe) begin
      out_data <= comb_out[STAGES-1][ACC_W-1:SHIFT]; // truncate, floor toward -inf
    end
  end

  // decimation point must come after a sample was integrated
  // and not on the first edge out of reset, when the integrators are still empty
  a_dec_after_in : assert property (
    @(posedge clock) disable iff (rst)
    dec_strobe |-> ($past(in_strobe) && !$past(rst))
  ) else $error("cic_decimator: dec_strobe not preceded by an integrated sample");

endmodule

//--- logic/iq_decimator.sv
`timescale 1ns/1ps

// rx decimation chain, top level
// I and Q share one strobe chain: /RATIO_1 then /RATIO_2
module iq_decimator
  import rx_pkg::*;
#(
  parameter int STAGES = cic_stages,
  parameter int RATIO_1 = ratio_1,
  parameter int RATIO_2 = ratio_2,
  parameter int IN_W = sample_w,
  parameter int OUT_W = out_w
) (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    in_strobe,  // mixer sample valid
  input  logic signed [IN_W-1:0]  in_i,
  input  logic signed [IN_W-1:0]  in_q,
  output logic                    out_strobe, // one per RATIO_1 * RATIO_2 inputs
  output logic signed [OUT_W-1:0] out_i,
  output logic signed [OUT_W-1:0] out_q
);

  logic dec1_strobe; // first decimation point, /RATIO_1
  logic dec2_strobe; // second decimation point, /RATIO_1*RATIO_2

  // between the filters, same width as the mixer samples
  logic signed [IN_W-1:0] stage1_i;
  logic signed [IN_W-1:0] stage1_q;

  logic signed [OUT_W-1:0] stage2_i; // unregistered chain output
  logic signed [OUT_W-1:0] stage2_q;

  // strobe chain
  rate_strobe #(
    .RATIO(RATIO_1)
  ) i_strobe_1 (
    .clock(clock),
    .rst(rst),
    .in_strobe(in_strobe),
    .out_strobe(dec1_strobe)
  );

  // counts first-stage outputs, not clocks
  rate_strobe #(
    .RATIO(RATIO_2)
  ) i_strobe_2 (
    .clock(clock),
    .rst(rst),
    .in_strobe(dec1_strobe),
    .out_strobe(dec2_strobe)
  );

  // first CIC, unity DC gain after truncation
  cic_decimator #(
    .STAGES(STAGES),
    .RATIO(RATIO_1),
    .IN_W(IN_W),
    .OUT_W(IN_W)
  ) i_cic1_i (
    .clock(clock),
    .rst(rst),
    .in_strobe(in_strobe),
    .dec_strobe(dec1_strobe),
    .in_data(in_i),
    .out_data(stage1_i)
  );

  cic_decimator #(
    .STAGES(STAGES),
    .RATIO(RATIO_1),
    .IN_W(IN_W),
    .OUT_W(IN_W)
  ) i_cic1_q (
    .clock(clock),
    .rst(rst),
    .in_strobe(in_strobe),
    .dec_strobe(dec1_strobe),
    .in_data(in_q),
    .out_data(stage1_q)
  );

  // second CIC, integrates each first-stage output once
  // widens to OUT_W, gain RATIO_2**STAGES over 2**shift
  cic_decimator #(
    .STAGES(STAGES),
    .RATIO(RATIO_2),
    .IN_W(IN_W),
    .OUT_W(OUT_W)
  ) i_cic2_i (
    .clock(clock),
    .rst(rst),
    .in_strobe(dec1_strobe),
    .dec_strobe(dec2_strobe),
    .in_data(stage1_i),
    .out_data(stage2_i)
  );

  cic_decimator #(
    .STAGES(STAGES),
    .RATIO(RATIO_2),
    .IN_W(IN_W),
    .OUT_W(OUT_W)
  ) i_cic2_q (
    .clock(clock),
    .rst(rst),
    .in_strobe(dec1_strobe),
    .dec_strobe(dec2_strobe),
    .in_data(stage1_q),
    .out_data(stage2_q)
  );

  // output register
  // pair held steady between strobes so the next block can read it any time
  always_ff @(posedge clock) begin
    if (rst) begin
      out_strobe <= 1'b0;
      out_i <= '0;
      out_q <= '0;
    end else begin
      out_strobe <= dec2_strobe; // one cycle behind the decimation point
      if (dec2_strobe) begin
        out_i <= stage2_i;
        out_q <= stage2_q;
      end
    end
  end

endmodule

//--- logic/rate_strobe.sv
`timescale 1ns/1ps

// decimated sample clock
// one out_strobe for every RATIO in_strobes, registered
module rate_strobe #(
  parameter int RATIO = 16
) (
  input  logic clock,
  input  logic rst,
  input  logic in_strobe,
  output logic out_strobe
);

  localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(RATIO - 1); // terminal count

  logic [CNT_W-1:0] cnt; // input strobes seen in this period
  logic wrap;

  // RATIO-th strobe of the period
  assign wrap = in_strobe && (cnt == LAST);

  // modulo-RATIO counter, only moves on a counted strobe
  always_ff @(posedge clock) begin
    if (rst) begin
      cnt <= '0;
    end else if (in_strobe) begin
      if (wrap) begin
        cnt <= '0; // start next period
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // pulse on the edge after the wrap
  always_ff @(posedge clock) begin
    if (rst) begin
      out_strobe <= 1'b0;
    end else begin
      out_strobe <= wrap; // low again next cycle unless RATIO is 1
    end
  end

  // output pulse always follows a counted input strobe
  a_out_after_in : assert property (
    @(posedge clock) disable iff (rst)
    out_strobe |-> $past(in_strobe)
  ) else $error("rate_strobe: out_strobe without a preceding in_strobe");

  // single-cycle pulse, never back to back
  a_out_single : assert property (
    @(posedge clock) disable iff (rst)
    out_strobe |=> !out_strobe
  ) else $error("rate_strobe: out_strobe high two cycles running");

endmodule

//--- logic/rx_pkg.sv
// shared constants for the rx decimation chain
// both CIC filters are built from these, and the bench reuses them
package rx_pkg;

  // mixer sample width, also the width between the two CIC filters
  localparam int sample_w = 18;

  localparam int out_w = 24; // final I/Q word to the downstream FIR

  localparam int cic_stages = 4; // order N, same for both filters

  // decimation ratios, 16 * 25 = 400 overall
  localparam int ratio_1 = 16;
  localparam int ratio_2 = 25;

  // bits of growth through an N-stage CIC with decimation R
  // DC gain is R**N, so the growth is the smallest g with 2**g >= R**N
  // i.e. ceil(N * log2(R)): 16 for R=16, 19 for R=25 (N=4)
  function automatic int bit_growth(input int stages, input int ratio);
    longint unsigned gain;
    int growth;
    gain = 1;
    for (int s = 0; s < stages; s++) begin
      gain = gain * longint'(ratio); // R**N
    end
    growth = 0;
    while ((64'd1 << growth) < gain) begin
      growth++;
    end
    return growth;
  endfunction

endpackage

//--- tb.f
+incdir+bench
logic/rx_pkg.sv
logic/rate_strobe.sv
logic/cic_decimator.sv
logic/iq_decimator.sv
bench/tb_iq_decimator.sv
